// File: rtl/renamePkg.sv
package renamePkg;

    // architectural state
    localparam int REG_NUM = 32;
    localparam int NAME_W  = 5;
    localparam int DATA_W  = 32;

    // nick 0 means the register file holds the value, ROB entry n owns nick n+1
    localparam int ROB_DEPTH = 8;
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH);
    localparam int NICK_W    = 4;

    localparam int OP_W   = 6;
    localparam int IMM_W  = 32;
    localparam int ADDR_W = 32;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef struct packed {
        logic [NAME_W-1:0] rd;
        logic [NAME_W-1:0] rs1;
        logic [NAME_W-1:0] rs2;
        logic [OP_W-1:0]   op;
        logic [ADDR_W-1:0] pc;
        logic [IMM_W-1:0]  imm;
        logic              pd;
    } decodedInstr;

    typedef struct packed {
        logic [NAME_W-1:0] rd;
        logic [OP_W-1:0]   op;
        logic [ADDR_W-1:0] pc;
        logic [IMM_W-1:0]  imm;
        logic              pd;
        logic [DATA_W-1:0] rs1Data;
        logic [DATA_W-1:0] rs2Data;
        logic [NICK_W-1:0] rs1Nick;
        logic [NICK_W-1:0] rs2Nick;
        logic [NICK_W-1:0] destNick;
    } dispatchBundle;

    typedef struct packed {
        logic [NICK_W-1:0] nick;
        logic [DATA_W-1:0] data;
    } execResult;

    typedef struct packed {
        logic [NAME_W-1:0] rd;
        logic [NICK_W-1:0] nick;
        logic [DATA_W-1:0] data;
    } commitInfo;

endpackage

// File: rtl/payloadFifo.sv
`timescale 1ns/1ps

module payloadFifo
    import renamePkg::*;
#(
    parameter type payloadT = logic [DATA_W-1:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outPop,
    output payloadT outData
);

    payloadT mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    assign inReady  = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign outValid = (count != '0);
    // head is visible before it is popped
    assign outData  = mem[rdPtr];

    assign push = inValid && inReady;
    assign pop  = outPop && outValid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile
    import renamePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              flush,
    input  logic              readEn,
    input  logic [NAME_W-1:0] rdName,
    input  logic [NAME_W-1:0] rs1Name,
    input  logic [NAME_W-1:0] rs2Name,
    input  logic [NICK_W-1:0] renameNick,
    output logic [DATA_W-1:0] rs1Data,
    output logic [DATA_W-1:0] rs2Data,
    output logic [NICK_W-1:0] rs1Nick,
    output logic [NICK_W-1:0] rs2Nick,
    input  logic              commitValid,
    input  commitInfo         commit
);

    logic [DATA_W-1:0] regData [REG_NUM];
    logic [NICK_W-1:0] regNick [REG_NUM];

    logic commitWrite;
    logic commitHit;
    logic rs1Fwd;
    logic rs2Fwd;

    assign commitWrite = commitValid && (commit.rd != '0);
    // tag only goes back to 0 if no younger rename took the register
    assign commitHit   = commitWrite && (regNick[commit.rd] == commit.nick);

    assign rs1Fwd = commitWrite && (commit.rd == rs1Name);
    assign rs2Fwd = commitWrite && (commit.rd == rs2Name);

    // sources see the state before this cycle's rename
    always_comb begin
        rs1Data = rs1Fwd ? commit.data : regData[rs1Name];
        rs1Nick = (rs1Fwd && commitHit) ? '0 : regNick[rs1Name];
        if (rs1Name == '0) begin
            rs1Data = '0;
            rs1Nick = '0;
        end

        rs2Data = rs2Fwd ? commit.data : regData[rs2Name];
        rs2Nick = (rs2Fwd && commitHit) ? '0 : regNick[rs2Name];
        if (rs2Name == '0) begin
            rs2Data = '0;
            rs2Nick = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regData[i] <= '0;
                regNick[i] <= '0;
            end
        end else begin
            // retired value is architectural even when the tag moved on
            if (commitWrite) begin
                regData[commit.rd] <= commit.data;
            end

            if (flush) begin
                for (int i = 0; i < REG_NUM; i++) begin
                    regNick[i] <= '0;
                end
            end else begin
                if (commitHit) begin
                    regNick[commit.rd] <= '0;
                end
                // a same-cycle rename of the committing register wins
                if (readEn && rdy && (rdName != '0)) begin
                    regNick[rdName] <= renameNick;
                end
            end
        end
    end

endmodule

// File: rtl/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer
    import renamePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              flush,
    input  logic              allocEn,
    input  logic [NAME_W-1:0] allocRd,
    output logic              allocReady,
    output logic [NICK_W-1:0] allocNick,
    input  logic              resValid,
    input  execResult         res,
    output logic              commitValid,
    output commitInfo         commit
);

    // per-entry state
    logic [ROB_DEPTH-1:0] occupied;
    logic [ROB_DEPTH-1:0] done;
    logic [NAME_W-1:0]    entryRd   [ROB_DEPTH];
    logic [DATA_W-1:0]    entryData [ROB_DEPTH];

    logic [ROB_PTR_W-1:0] head;
    logic [ROB_PTR_W-1:0] tail;

    logic                 doAlloc;
    logic                 doCommit;
    logic                 nickInRange;
    logic                 resHit;
    logic [ROB_PTR_W-1:0] resIdx;

    function automatic logic [ROB_PTR_W-1:0] nextPtr(input logic [ROB_PTR_W-1:0] ptr);
        logic [ROB_PTR_W-1:0] nxt;
        if (ptr == ROB_PTR_W'(ROB_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    function automatic logic [NICK_W-1:0] idxToNick(input logic [ROB_PTR_W-1:0] idx);
        return NICK_W'(idx) + NICK_W'(1);
    endfunction

    // full when the tail slot is still in use
    assign allocReady = !occupied[tail];
    assign allocNick  = idxToNick(tail);

    assign doAlloc  = allocEn && allocReady && rdy && !flush;
    assign doCommit = occupied[head] && done[head] && rdy && !flush;

    // results for nick 0, out-of-range nicks or free entries fall on the floor
    assign nickInRange = (res.nick != '0) && (res.nick <= NICK_W'(ROB_DEPTH));
    assign resIdx      = ROB_PTR_W'(res.nick - NICK_W'(1));
    assign resHit      = resValid && nickInRange && occupied[resIdx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied    <= '0;
            done        <= '0;
            head        <= '0;
            tail        <= '0;
            commitValid <= 1'b0;
        end else begin
            commitValid <= doCommit;

            if (doAlloc) begin
                occupied[tail] <= 1'b1;
                done[tail]     <= 1'b0;
                tail           <= nextPtr(tail);
            end

            if (resHit) begin
                done[resIdx] <= 1'b1;
            end

            // head is freed in the cycle it is seen done
            if (doCommit) begin
                occupied[head] <= 1'b0;
                done[head]     <= 1'b0;
                head           <= nextPtr(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            entryRd[tail] <= allocRd;
        end
        if (resHit && !flush) begin
            entryData[resIdx] <= res.data;
        end
    end

    always_ff @(posedge clk) begin
        if (doCommit) begin
            commit.rd   <= entryRd[head];
            commit.nick <= idxToNick(head);
            commit.data <= entryData[head];
        end
    end

endmodule

// File: rtl/renameTop.sv
`timescale 1ns/1ps

module renameTop
    import renamePkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          flush,
    input  logic          decValid,
    output logic          decReady,
    input  decodedInstr   decInstr,
    input  logic          resValid,
    output logic          resReady,
    input  execResult     res,
    output logic          dispValid,
    output dispatchBundle disp,
    output logic          commitValid,
    output commitInfo     commit
);

    logic              decOutValid;
    decodedInstr       decHead;
    logic              dispPop;

    logic              resOutValid;
    execResult         resHead;
    logic              resPop;

    logic              allocReady;
    logic [NICK_W-1:0] allocNick;

    logic [DATA_W-1:0] rs1Data;
    logic [DATA_W-1:0] rs2Data;
    logic [NICK_W-1:0] rs1Nick;
    logic [NICK_W-1:0] rs2Nick;

    // rename, source read and ROB allocation all happen on the pop
    assign dispPop = decOutValid && rdy && !flush && allocReady;
    assign resPop  = resOutValid && rdy;

    payloadFifo #(
        .payloadT (decodedInstr)
    ) decQueue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .inValid  (decValid),
        .inReady  (decReady),
        .inData   (decInstr),
        .outValid (decOutValid),
        .outPop   (dispPop),
        .outData  (decHead)
    );

    payloadFifo #(
        .payloadT (execResult)
    ) resQueue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (res),
        .outValid (resOutValid),
        .outPop   (resPop),
        .outData  (resHead)
    );

    regFile rf (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .readEn      (dispPop),
        .rdName      (decHead.rd),
        .rs1Name     (decHead.rs1),
        .rs2Name     (decHead.rs2),
        .renameNick  (allocNick),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .rs1Nick     (rs1Nick),
        .rs2Nick     (rs2Nick),
        .commitValid (commitValid),
        .commit      (commit)
    );

    reorderBuffer rob (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .allocEn     (dispPop),
        .allocRd     (decHead.rd),
        .allocReady  (allocReady),
        .allocNick   (allocNick),
        .resValid    (resPop),
        .res         (resHead),
        .commitValid (commitValid),
        .commit      (commit)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            dispValid <= 1'b0;
        end else begin
            dispValid <= dispPop;
        end
    end

    // bundle lands one cycle after the pop
    always_ff @(posedge clk) begin
        if (dispPop) begin
            disp.rd       <= decHead.rd;
            disp.op       <= decHead.op;
            disp.pc       <= decHead.pc;
            disp.imm      <= decHead.imm;
            disp.pd       <= decHead.pd;
            disp.rs1Data  <= rs1Data;
            disp.rs2Data  <= rs2Data;
            disp.rs1Nick  <= rs1Nick;
            disp.rs2Nick  <= rs2Nick;
            disp.destNick <= allocNick;
        end
    end

endmodule

// File: test/renameTop_asserts.sv
`timescale 1ns/1ps

module renameTop_asserts
    import renamePkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input logic                  dispValid,
    input logic                  commitValid,
    input commitInfo             commit,
    input logic [FIFO_CNT_W-1:0] decCount
);

    // nothing leaves the slice in the cycle after a flush
    flushQuiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!dispValid && !commitValid))
        else $error("dispatch or commit pulse in the cycle after flush");

    // a push taken while full would carry the count past the depth
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        decCount <= FIFO_CNT_W'(FIFO_DEPTH))
        else $error("decode queue count above its depth");

    // nick 0 belongs to the register file, never to a ROB entry
    nickNonZero: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> (commit.nick != '0))
        else $error("commit with nick 0");

endmodule

bind renameTop renameTop_asserts renameTop_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .dispValid   (dispValid),
    .commitValid (commitValid),
    .commit      (commit),
    .decCount    (decQueue.count)
);

// File: test/renameTb.sv
`timescale 1ns/1ps

module renameTb
    import renamePkg::*;
();

    typedef enum int {ISSUE, RESULT, FLUSH, STALL, FULL, DRAIN} stepKind;

    // ISSUE uses a=rd b=rs1 c=rs2, RESULT a=issue index, STALL a=cycles
    typedef struct packed {
        stepKind kind;
        int      a;
        int      b;
        int      c;
    } stepT;

    localparam int NUM_STEPS  = 54;
    localparam int MAX_ISSUE  = 32;
    localparam int WAIT_LIMIT = 200;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          flush;
    logic          decValid;
    logic          decReady;
    decodedInstr   decInstr;
    logic          resValid;
    logic          resReady;
    execResult     res;
    logic          dispValid;
    dispatchBundle disp;
    logic          commitValid;
    commitInfo     commit;

    stepT steps [NUM_STEPS];

    // reference model of tags and values
    logic [DATA_W-1:0] modelVal [REG_NUM];
    logic [NICK_W-1:0] modelNick [REG_NUM];
    logic [NICK_W-1:0] nextNick;
    decodedInstr       issued [MAX_ISSUE];
    logic [NICK_W-1:0] issuedNick [MAX_ISSUE];
    logic              isDispatched [MAX_ISSUE];
    logic              resDone [MAX_ISSUE];
    logic [DATA_W-1:0] resData [MAX_ISSUE];
    int                pendQ [$];
    int                dispNext;
    int                issueCount;
    int                checks;
    int                errors;
    logic              timedOut;

    renameTop renameTop_inst (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .decValid    (decValid),
        .decReady    (decReady),
        .decInstr    (decInstr),
        .resValid    (resValid),
        .resReady    (resReady),
        .res         (res),
        .dispValid   (dispValid),
        .disp        (disp),
        .commitValid (commitValid),
        .commit      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic waitTick(input string what, inout int n);
        @(posedge clk);
        #1;
        n++;
        if (n > WAIT_LIMIT && !timedOut) begin
            timedOut = 1'b1;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic issueInstr(input int rd, input int rs1, input int rs2);
        decodedInstr ins;
        int          n;
        n       = 0;
        ins.rd  = NAME_W'(rd);
        ins.rs1 = NAME_W'(rs1);
        ins.rs2 = NAME_W'(rs2);
        ins.op  = OP_W'(issueCount + 3);
        ins.pc  = ADDR_W'(32'h0000_1000 + 4 * issueCount);
        ins.imm = $urandom;
        ins.pd  = issueCount[0];
        decInstr = ins;
        decValid = 1'b1;
        while (!decReady && !timedOut) begin
            waitTick("decReady", n);
        end
        @(posedge clk);
        issued[issueCount]     = ins;
        issuedNick[issueCount] = nextNick;
        resDone[issueCount]    = 1'b0;
        nextNick = (nextNick == NICK_W'(ROB_DEPTH)) ? NICK_W'(1) : nextNick + 1'b1;
        issueCount++;
        #1;
        decValid = 1'b0;
    endtask

    task automatic returnResult(input int idx);
        int n;
        n = 0;
        // the ROB drops results for entries it has not allocated
        while (!isDispatched[idx] && !timedOut) begin
            waitTick("dispatch of the result's instruction", n);
        end
        res.nick = issuedNick[idx];
        res.data = $urandom;
        resValid = 1'b1;
        while (!resReady && !timedOut) begin
            waitTick("resReady", n);
        end
        @(posedge clk);
        resDone[idx] = 1'b1;
        resData[idx] = res.data;
        #1;
        resValid = 1'b0;
    endtask

    task automatic flushPipeline();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush    = 1'b0;
        nextNick = NICK_W'(1);
    endtask

    task automatic stallCycles(input int cycles);
        rdy = 1'b0;
        // nothing leaves the slice while rdy is low
        repeat (cycles) begin
            @(posedge clk);
            #1;
            checkEq("dispValid", 64'(dispValid), 64'(0));
            checkEq("commitValid", 64'(commitValid), 64'(0));
        end
        rdy = 1'b1;
    endtask

    task automatic expectFull();
        int n;
        n = 0;
        while (decReady && !timedOut) begin
            waitTick("decReady to fall", n);
        end
        // leave room for a late dispatch to show up
        repeat (4) @(posedge clk);
        #1;
        checkEq("queued instructions", 64'(issueCount - dispNext), 64'(FIFO_DEPTH));
        checkEq("decReady", 64'(decReady), 64'(0));
    endtask

    task automatic drainInFlight();
        int n;
        n = 0;
        while ((dispNext != issueCount || (pendQ.size() != 0 && resDone[pendQ[0]]))
               && !timedOut) begin
            waitTick("in-flight instructions to finish", n);
        end
    endtask

    // dispatch is checked before commit, both read the state of the cycle before
    always @(negedge clk) begin : monitor
        int          idx;
        decodedInstr ins;
        if (rst) begin
            for (int r = 0; r < REG_NUM; r++) begin
                modelVal[r]  = '0;
                modelNick[r] = '0;
            end
            for (int k = 0; k < MAX_ISSUE; k++) begin
                isDispatched[k] = 1'b0;
            end
            pendQ.delete();
            dispNext = 0;
        end else begin
            if (dispValid) begin
                if (dispNext >= issueCount) begin
                    errors++;
                    $display("dispatch pulse with no instruction waiting");
                end else begin
                    idx = dispNext;
                    ins = issued[idx];
                    dispNext++;
                    checkEq("disp.rd", 64'(disp.rd), 64'(ins.rd));
                    checkEq("disp.op", 64'(disp.op), 64'(ins.op));
                    checkEq("disp.pc", 64'(disp.pc), 64'(ins.pc));
                    checkEq("disp.imm", 64'(disp.imm), 64'(ins.imm));
                    checkEq("disp.pd", 64'(disp.pd), 64'(ins.pd));
                    checkEq("disp.rs1Data", 64'(disp.rs1Data), 64'(modelVal[ins.rs1]));
                    checkEq("disp.rs2Data", 64'(disp.rs2Data), 64'(modelVal[ins.rs2]));
                    checkEq("disp.rs1Nick", 64'(disp.rs1Nick), 64'(modelNick[ins.rs1]));
                    checkEq("disp.rs2Nick", 64'(disp.rs2Nick), 64'(modelNick[ins.rs2]));
                    checkEq("disp.destNick", 64'(disp.destNick), 64'(issuedNick[idx]));
                    isDispatched[idx] = 1'b1;
                    pendQ.push_back(idx);
                    if (ins.rd != '0) begin
                        modelNick[ins.rd] = issuedNick[idx];
                    end
                end
            end
            if (commitValid) begin
                if (pendQ.size() == 0) begin
                    errors++;
                    $display("commit pulse with nothing in flight");
                end else begin
                    idx = pendQ.pop_front();
                    ins = issued[idx];
                    if (!resDone[idx]) begin
                        errors++;
                        $display("issue %0d committed before its result came back", idx);
                    end
                    checkEq("commit.rd", 64'(commit.rd), 64'(ins.rd));
                    checkEq("commit.nick", 64'(commit.nick), 64'(issuedNick[idx]));
                    checkEq("commit.data", 64'(commit.data), 64'(resData[idx]));
                    if (ins.rd != '0) begin
                        modelVal[ins.rd] = resData[idx];
                        if (modelNick[ins.rd] == issuedNick[idx]) begin
                            modelNick[ins.rd] = '0;
                        end
                    end
                end
            end
            // undispatched instructions are dropped along with the tags
            if (flush) begin
                for (int r = 0; r < REG_NUM; r++) begin
                    modelNick[r] = '0;
                end
                pendQ.delete();
                dispNext = issueCount;
            end
        end
    end

    initial begin
        stepT cur;
        void'($urandom(32'hf79ebc07));
        rst        = 1'b1;
        rdy        = 1'b1;
        flush      = 1'b0;
        decValid   = 1'b0;
        decInstr   = '0;
        resValid   = 1'b0;
        res        = '0;
        nextNick   = NICK_W'(1);
        issueCount = 0;
        checks     = 0;
        errors     = 0;
        timedOut   = 1'b0;
        steps = '{
            '{ISSUE, 1, 0, 0}, '{ISSUE, 2, 1, 2}, '{ISSUE, 1, 1, 2}, '{DRAIN, 0, 0, 0},
            '{RESULT, 0, 0, 0}, '{DRAIN, 0, 0, 0}, '{ISSUE, 3, 1, 2}, '{RESULT, 2, 0, 0},
            '{RESULT, 1, 0, 0}, '{RESULT, 3, 0, 0}, '{DRAIN, 0, 0, 0}, '{ISSUE, 0, 1, 3},
            '{RESULT, 4, 0, 0}, '{DRAIN, 0, 0, 0}, '{ISSUE, 4, 2, 0}, '{STALL, 6, 0, 0},
            '{RESULT, 5, 0, 0}, '{STALL, 3, 0, 0}, '{DRAIN, 0, 0, 0}, '{ISSUE, 5, 4, 3},
            '{ISSUE, 6, 5, 1}, '{ISSUE, 7, 6, 6}, '{ISSUE, 8, 7, 0}, '{ISSUE, 9, 8, 2},
            '{ISSUE, 10, 9, 4}, '{ISSUE, 11, 1, 10}, '{ISSUE, 12, 11, 5}, '{ISSUE, 13, 12, 12},
            '{ISSUE, 14, 13, 3}, '{ISSUE, 15, 14, 9}, '{ISSUE, 16, 15, 1}, '{FULL, 0, 0, 0},
            '{RESULT, 9, 0, 0}, '{RESULT, 6, 0, 0}, '{STALL, 2, 0, 0}, '{RESULT, 7, 0, 0},
            '{RESULT, 8, 0, 0}, '{RESULT, 13, 0, 0}, '{RESULT, 10, 0, 0}, '{RESULT, 12, 0, 0},
            '{RESULT, 11, 0, 0}, '{DRAIN, 0, 0, 0}, '{RESULT, 14, 0, 0}, '{RESULT, 16, 0, 0},
            '{RESULT, 15, 0, 0}, '{RESULT, 17, 0, 0}, '{DRAIN, 0, 0, 0}, '{ISSUE, 5, 16, 0},
            '{ISSUE, 6, 5, 5}, '{DRAIN, 0, 0, 0}, '{FLUSH, 0, 0, 0}, '{ISSUE, 7, 5, 6},
            '{RESULT, 20, 0, 0}, '{DRAIN, 0, 0, 0}
        };
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // both queues empty and no pulses out of reset
        checkEq("decReady", 64'(decReady), 64'(1));
        checkEq("resReady", 64'(resReady), 64'(1));
        checkEq("dispValid", 64'(dispValid), 64'(0));
        checkEq("commitValid", 64'(commitValid), 64'(0));
        for (int i = 0; i < NUM_STEPS && !timedOut; i++) begin
            cur = steps[i];
            case (cur.kind)
                ISSUE:   issueInstr(cur.a, cur.b, cur.c);
                RESULT:  returnResult(cur.a);
                FLUSH:   flushPipeline();
                STALL:   stallCycles(cur.a);
                FULL:    expectFull();
                default: drainInFlight();
            endcase
            $display("step %0d %s done, errors so far %0d", i, cur.kind.name(), errors);
        end
        $display("%0d issued, %0d checks, %0d errors", issueCount, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/renamePkg.sv
rtl/payloadFifo.sv
rtl/regFile.sv
rtl/reorderBuffer.sv
rtl/renameTop.sv
test/renameTop_asserts.sv
test/renameTb.sv

// File: run.sh
#!/bin/sh
# build and run the rename slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module renameTb -f verilog.f -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
